// File: src.f
verilog/cpu_pkg.sv
verilog/if_stage.sv
verilog/id_stage.sv
verilog/regfile.sv
verilog/ex_stage.sv
verilog/cpu_core.sv
tb/tb_core.sv

// File: run.sh
#!/bin/sh
# compile and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_core -o tb_core_sim
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

out=$(./obj_dir/tb_core_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qF 'All tests passed!'; then
   exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: tb/tb_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_core;
   import cpu_pkg::*;

   localparam int          CLK_HALF        = 10;            // 20 ns period
   localparam int          RESET_CYCLES    = 8;
   localparam int          N_COMMITS       = 96;
   localparam int          WATCHDOG_CYCLES = N_COMMITS * 10;
   localparam int          MEM_WORDS       = 256;
   localparam int          JAL_EVERY       = 12;            // one forward jump per block
   localparam logic [31:0] LFSR_SEED       = 32'hd189;
   localparam logic [31:0] LFSR_TAPS       = 32'h8020_0003; // x^32+x^22+x^2+x+1

   logic        clk;
   logic        rst;
   logic        wb_cyc;
   logic        wb_stb;
   addr_t       wb_adr;
   word_t       wb_dat;
   logic        wb_ack;
   commit_t     commit;

   word_t       mem [0:MEM_WORDS-1];                      // instruction memory
   logic [1:0]  jal_skip [0:MEM_WORDS-1];                 // words skipped by the jal in a slot
   logic [31:0] lfsr_q;
   word_t       model_rf [0:31];                          // reference register state
   addr_t       model_pc;
   int          commit_count;
   logic        seen_first_fetch;
   logic        req_pending;                              // slave holds a cycle
   int          wait_left;
   addr_t       req_adr;
   addr_t       exp_pc;
   reg_addr_t   exp_rd;
   word_t       exp_data;

   cpu_core u_dut (
      .clk_i    (clk),
      .rst_i    (rst),
      .wb_cyc_o (wb_cyc),
      .wb_stb_o (wb_stb),
      .wb_adr_o (wb_adr),
      .wb_dat_i (wb_dat),
      .wb_ack_i (wb_ack),
      .commit_o (commit)
   );

   initial
   begin
      clk = 1'b0;
      forever #CLK_HALF clk = ~clk;
   end

   // ##############################
   // random source and program
   // ##############################
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      if (s[0])
         return (s >> 1) ^ LFSR_TAPS;
      return s >> 1;
   endfunction

   // one lfsr step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int k = 0; k < n; k++)
      begin
         lfsr_q = lfsr_next(lfsr_q);
         v      = {v[30:0], lfsr_q[0]};
      end
      return v;
   endfunction

   function automatic word_t rand_alu();
      logic        imm_form;
      logic [2:0]  f3;
      logic [2:0]  rd;
      logic [2:0]  rs1;
      logic [2:0]  rs2;
      logic        alt;
      logic [11:0] imm;
      logic [6:0]  f7;
      imm_form = 1'(rand_bits(1));
      f3       = 3'(rand_bits(3));
      rd       = 3'(rand_bits(3));                         // x0..x7 only, dense hazards
      rs1      = 3'(rand_bits(3));
      rs2      = 3'(rand_bits(3));
      alt      = 1'(rand_bits(1));                         // sub / sra
      imm      = 12'(rand_bits(12));
      if (!imm_form)
      begin
         f7 = (alt && ((f3 == 3'b000) || (f3 == 3'b101))) ? 7'b0100000 : 7'b0000000;
         return {f7, 2'b00, rs2, 2'b00, rs1, f3, 2'b00, rd, OPC_OP};
      end
      if (f3 == 3'b001)
         imm = {7'b0000000, imm[4:0]};                     // slli
      else if (f3 == 3'b101)
         imm = {(alt ? 7'b0100000 : 7'b0000000), imm[4:0]};  // srli/srai
      return {imm, 2'b00, rs1, f3, 2'b00, rd, OPC_OP_IMM};
   endfunction

   // forward jal over skip words
   function automatic word_t make_jal(input logic [1:0] skip, input logic [2:0] rd);
      logic [20:0] off;
      off = {17'd0, skip, 2'b00} + 21'd4;
      return {off[20], off[10:1], off[11], off[19:12], 2'b00, rd, OPC_JAL};
   endfunction

   task automatic fill_program();
      logic [1:0] skip;
      logic [2:0] link_rd;
      for (int i = 0; i < MEM_WORDS; i++)
      begin
         if ((i % JAL_EVERY) == (JAL_EVERY - 1))
         begin
            skip = 2'(rand_bits(2));
            if (skip == 2'd0)
               skip = 2'd1;                                // 1..3 words skipped
            link_rd     = 3'(rand_bits(3));
            mem[i]      = make_jal(skip, link_rd);
            jal_skip[i] = skip;
         end
         else
         begin
            mem[i]      = rand_alu();
            jal_skip[i] = 2'd0;
         end
      end
   endtask

   // ##############################
   // reference model
   // ##############################
   task automatic model_step(output addr_t pc, output reg_addr_t rd, output word_t wdata);
      word_t      ins;
      logic [2:0] f3;
      logic       is_jump;
      word_t      a;
      word_t      b;
      word_t      r;
      addr_t      next_pc;
      ins     = mem[model_pc[9:2]];
      f3      = ins[14:12];
      rd      = ins[11:7];
      pc      = model_pc;
      a       = model_rf[ins[19:15]];
      next_pc = model_pc + 32'd4;
      is_jump = (ins[6:0] == OPC_JAL);
      if (ins[6:0] == OPC_OP)
         b = model_rf[ins[24:20]];
      else
         b = 32'($signed(ins[31:20]));                     // shamt sits in b[4:0]
      case (f3)
         3'b000:  r = ((ins[6:0] == OPC_OP) && ins[30]) ? a - b : a + b;
         3'b001:  r = a << b[4:0];
         3'b010:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         3'b011:  r = (a < b) ? 32'd1 : 32'd0;
         3'b100:  r = a ^ b;
         3'b101:
         begin
            if (ins[30])
               r = $signed(a) >>> b[4:0];                  // sign fill
            else
               r = a >> b[4:0];
         end
         3'b110:  r = a | b;
         default: r = a & b;
      endcase
      if (is_jump)
      begin
         r       = model_pc + 32'd4;                       // link
         next_pc = model_pc + 32'd4 + {28'd0, jal_skip[model_pc[9:2]], 2'b00};
      end
      if (rd != 5'd0)
         model_rf[rd] = r;
      wdata    = r;
      model_pc = next_pc;
   endtask

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Test failures found");
      $fatal(1, "simulation stopped at first error");
   endtask

   // ##############################
   // wishbone slave, 0..3 waits
   // ##############################
   always @(posedge clk)
   begin
      if (rst)
      begin
         wb_ack      <= 1'b0;
         req_pending = 1'b0;
      end
      else if (wb_ack)
         wb_ack <= 1'b0;                                   // single beat
      else if (wb_cyc && wb_stb)
      begin
         if (!req_pending)
         begin
            req_pending = 1'b1;
            req_adr     = wb_adr;
            wait_left   = int'(rand_bits(2));
         end
         assert (wb_adr == req_adr)
         else abort_run($sformatf("ERR at %0d ns: fetch address moved from %h to %h",
                                  $time, req_adr, wb_adr));
         if (wait_left == 0)
         begin
            wb_ack      <= 1'b1;
            wb_dat      <= mem[wb_adr[9:2]];
            req_pending = 1'b0;
         end
         else
            wait_left--;
      end
   end

   // ##############################
   // commit checks
   // ##############################
   always @(posedge clk)
   begin
      if (rst)
      begin
         assert ((wb_cyc !== 1'b1) && (commit.valid !== 1'b1))
         else abort_run("bus cycle or commit seen while reset is asserted");
      end
      else
      begin
         if (wb_cyc && !seen_first_fetch)
         begin
            seen_first_fetch = 1'b1;
            assert (wb_adr == 32'h0)
            else abort_run($sformatf("ERR at %0d ns: first fetch at %h, expected 0",
                                     $time, wb_adr));
         end
         if (commit.valid && (commit_count < N_COMMITS))
         begin
            model_step(exp_pc, exp_rd, exp_data);
            assert (commit.pc == exp_pc)
            else abort_run($sformatf("ERR at %0d ns: commit pc %h, expected %h",
                                     $time, commit.pc, exp_pc));
            assert (commit.rd == exp_rd)
            else abort_run($sformatf("ERR at %0d ns: pc %h rd x%0d, expected x%0d",
                                     $time, exp_pc, commit.rd, exp_rd));
            assert (commit.wreg)
            else abort_run($sformatf("ERR at %0d ns: pc %h committed without wreg",
                                     $time, exp_pc));
            assert ((exp_rd == 5'd0) || (commit.wdata == exp_data))  // x0 data ignored
            else abort_run($sformatf("ERR at %0d ns: pc %h data %h, expected %h",
                                     $time, exp_pc, commit.wdata, exp_data));
            commit_count++;
         end
      end
   end

   initial
   begin
      rst              = 1'b1;
      wb_ack           = 1'b0;
      wb_dat           = '0;
      lfsr_q           = LFSR_SEED;
      commit_count     = 0;
      seen_first_fetch = 1'b0;
      req_pending      = 1'b0;
      wait_left        = 0;
      req_adr          = '0;
      model_pc         = 32'h0;
      for (int i = 0; i < 32; i++)
         model_rf[i] = '0;
      fill_program();
      repeat (RESET_CYCLES) @(posedge clk);
      rst <= 1'b0;
      wait (commit_count == N_COMMITS);
      $display("All tests passed!");
      $finish;
   end

   // watchdog
   initial
   begin
      repeat (RESET_CYCLES + WATCHDOG_CYCLES) @(posedge clk);
      abort_run($sformatf("timeout: only %0d of %0d commits seen", commit_count, N_COMMITS));
   end

endmodule

`default_nettype wire

// File: verilog/cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core (
   input  wire              logic clk_i,
   input  wire              logic rst_i,
   output logic             wb_cyc_o,
   output logic             wb_stb_o,
   output cpu_pkg::addr_t   wb_adr_o,
   input  cpu_pkg::word_t   wb_dat_i,
   input  wire              logic wb_ack_i,
   output cpu_pkg::commit_t commit_o
);
   import cpu_pkg::*;

   fetch_t    fetch;                                 // fetch -> decode
   issue_t    issue;                                 // decode -> execute
   commit_t   fwd;                                   // execute result, unregistered
   commit_t   commit;                                // write-back
   logic      redirect;
   addr_t     target;
   reg_addr_t ra_a;
   reg_addr_t ra_b;
   word_t     rd_a;
   word_t     rd_b;

   if_stage u_if (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .redirect_i (redirect),
      .target_i   (target),
      .wb_cyc_o   (wb_cyc_o),
      .wb_stb_o   (wb_stb_o),
      .wb_adr_o   (wb_adr_o),
      .wb_dat_i   (wb_dat_i),
      .wb_ack_i   (wb_ack_i),
      .fetch_o    (fetch)
   );

   id_stage u_id (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .fetch_i    (fetch),
      .ra_a_o     (ra_a),
      .ra_b_o     (ra_b),
      .rd_a_i     (rd_a),
      .rd_b_i     (rd_b),
      .fwd_i      (fwd),
      .issue_o    (issue),
      .redirect_o (redirect),
      .target_o   (target)
   );

   regfile u_rf (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .ra_a_i     (ra_a),
      .ra_b_i     (ra_b),
      .rd_a_o     (rd_a),
      .rd_b_o     (rd_b),
      .commit_i   (commit)
   );

   ex_stage u_ex (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .issue_i    (issue),
      .fwd_o      (fwd),
      .commit_o   (commit)
   );

   assign commit_o = commit;                         // retired writes go out as-is

endmodule

`default_nettype wire

// File: verilog/ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
   input  wire              logic clk_i,
   input  wire              logic rst_i,
   input  cpu_pkg::issue_t  issue_i,
   output cpu_pkg::commit_t fwd_o,              // combinational, back to decode
   output cpu_pkg::commit_t commit_o            // registered write-back
);
   import cpu_pkg::*;

   word_t   op_a;
   word_t   op_b;
   word_t   logic_res;
   word_t   shift_res;
   word_t   arith_res;
   word_t   b_mux;
   word_t   sum;
   logic    a_lt_b;
   word_t   result;
   commit_t commit_q;

   assign op_a = issue_i.op_a;
   assign op_b = issue_i.op_b;

   // ##############################
   // logic unit
   // ##############################
   always_comb
   begin
      case (issue_i.alu_op)
         OP_AND:  logic_res = op_a & op_b;
         OP_OR:   logic_res = op_a | op_b;
         OP_XOR:  logic_res = op_a ^ op_b;
         default: logic_res = '0;
      endcase
   end

   // ##############################
   // shift unit
   // ##############################
   always_comb
   begin
      case (issue_i.alu_op)
         OP_SLL:  shift_res = op_a << op_b[4:0];    // low five bits only
         OP_SRL:  shift_res = op_a >> op_b[4:0];
         OP_SRA:                                     // sign bits shifted in from the top
            shift_res = ({32{op_a[31]}} << (6'd32 - {1'b0, op_b[4:0]})) | (op_a >> op_b[4:0]);
         default: shift_res = '0;
      endcase
   end

   // ##############################
   // arithmetic unit
   // ##############################
   // sub and slt add the two's complement
   assign b_mux = ((issue_i.alu_op == OP_SUB) || (issue_i.alu_op == OP_SLT)) ?
                  (~op_b) + 32'd1 : op_b;
   assign sum   = op_a + b_mux;

   // signed: neg vs pos, or same sign and negative difference
   assign a_lt_b = (issue_i.alu_op == OP_SLT) ?
                   ((op_a[31] && !op_b[31]) ||
                    (!op_a[31] && !op_b[31] && sum[31]) ||
                    (op_a[31] && op_b[31] && sum[31])) :
                   (op_a < op_b);                    // unsigned

   always_comb
   begin
      case (issue_i.alu_op)
         OP_SLT, OP_SLTU: arith_res = {31'd0, a_lt_b};  // 0 or 1
         OP_ADD, OP_SUB:  arith_res = sum;
         default:         arith_res = '0;
      endcase
   end

   // result group select
   always_comb
   begin
      case (issue_i.alu_sel)
         SEL_LOGIC: result = logic_res;
         SEL_SHIFT: result = shift_res;
         SEL_ARITH: result = arith_res;
         SEL_JUMP:  result = issue_i.link;          // jal writes pc+4
         default:   result = '0;
      endcase
   end

   assign fwd_o = '{valid: issue_i.valid, pc: issue_i.pc, rd: issue_i.rd,
                    wreg: issue_i.wreg, wdata: result};

   // execute/write-back register
   always_ff @(posedge clk_i)
   begin
      if (rst_i)
         commit_q.valid <= 1'b0;
      else
         commit_q <= fwd_o;
   end

   assign commit_o = commit_q;

   // decode must never ask for a write with no result group
   a_no_blind_write : assert property (@(posedge clk_i) disable iff (rst_i)
                                       issue_i.valid && (issue_i.alu_sel == SEL_NONE)
                                       |-> !issue_i.wreg);

endmodule

`default_nettype wire

// File: verilog/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile (
   input  wire                logic clk_i,
   input  wire                logic rst_i,
   input  cpu_pkg::reg_addr_t ra_a_i,
   input  cpu_pkg::reg_addr_t ra_b_i,
   output cpu_pkg::word_t     rd_a_o,
   output cpu_pkg::word_t     rd_b_o,
   input  cpu_pkg::commit_t   commit_i
);
   import cpu_pkg::*;

   word_t rf_q [1:31];                               // x0 not stored
   logic  we;

   assign we = commit_i.valid && commit_i.wreg && (commit_i.rd != 5'd0);

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         for (int i = 1; i < 32; i++)
            rf_q[i] <= '0;                           // all clear after reset
      end
      else if (we)
         rf_q[commit_i.rd] <= commit_i.wdata;
   end

   // read port a, write-through on same-cycle hit
   always_comb
   begin
      if (ra_a_i == 5'd0)
         rd_a_o = '0;                                // hardwired zero
      else if (we && (commit_i.rd == ra_a_i))
         rd_a_o = commit_i.wdata;                    // bypass the write
      else
         rd_a_o = rf_q[ra_a_i];
   end

   // read port b, same rules
   always_comb
   begin
      if (ra_b_i == 5'd0)
         rd_b_o = '0;
      else if (we && (commit_i.rd == ra_b_i))
         rd_b_o = commit_i.wdata;
      else
         rd_b_o = rf_q[ra_b_i];
   end

endmodule

`default_nettype wire

// File: verilog/id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage (
   input  wire                logic clk_i,
   input  wire                logic rst_i,
   input  cpu_pkg::fetch_t    fetch_i,
   output cpu_pkg::reg_addr_t ra_a_o,
   output cpu_pkg::reg_addr_t ra_b_o,
   input  cpu_pkg::word_t     rd_a_i,
   input  cpu_pkg::word_t     rd_b_i,
   input  cpu_pkg::commit_t   fwd_i,          // live execute result
   output cpu_pkg::issue_t    issue_o,
   output logic               redirect_o,
   output cpu_pkg::addr_t     target_o
);
   import cpu_pkg::*;

   word_t     instr;
   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   reg_addr_t rd;
   word_t     imm_i;
   word_t     imm_j;
   logic      in_valid;
   logic      is_op;
   logic      is_imm;
   logic      is_jal;
   logic      is_shift;
   logic      f7_ok;
   logic      fwd_ok;
   word_t     src_a;
   word_t     src_b;
   alu_op_e   alu_op;
   alu_sel_e  alu_sel;
   issue_t    issue_d;
   issue_t    issue_q;
   logic      redirect_q;
   addr_t     target_q;

   // ##############################
   // field extraction
   // ##############################
   assign instr  = fetch_i.instr;
   assign opcode = instr[6:0];
   assign rd     = instr[11:7];
   assign funct3 = instr[14:12];
   assign funct7 = instr[31:25];
   assign ra_a_o = instr[19:15];                     // rs1
   assign ra_b_o = instr[24:20];                     // rs2

   assign imm_i = {{20{instr[31]}}, instr[31:20]};   // sign extended
   assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

   assign in_valid = fetch_i.valid && !redirect_q;   // squash the slot after a jal
   assign is_op    = (opcode == OPC_OP);
   assign is_imm   = (opcode == OPC_OP_IMM);
   assign is_jal   = (opcode == OPC_JAL);
   assign is_shift = (funct3 == 3'b001) || (funct3 == 3'b101);

   // ##############################
   // operand select with forwarding
   // ##############################
   assign fwd_ok = fwd_i.valid && fwd_i.wreg && (fwd_i.rd != 5'd0);  // x0 never forwarded

   assign src_a = (fwd_ok && (fwd_i.rd == ra_a_o)) ? fwd_i.wdata : rd_a_i;
   assign src_b = (fwd_ok && (fwd_i.rd == ra_b_o)) ? fwd_i.wdata : rd_b_i;

   // funct7 legality per form
   always_comb
   begin
      if (is_op)
         f7_ok = (funct7 == 7'b0000000) ||
                 ((funct7 == 7'b0100000) && ((funct3 == 3'b000) || (funct3 == 3'b101)));
      else if (funct3 == 3'b001)
         f7_ok = (funct7 == 7'b0000000);             // slli
      else if (funct3 == 3'b101)
         f7_ok = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);  // srli/srai
      else
         f7_ok = 1'b1;                               // plain immediates
   end

   // op and group decode, mixed selectors as in execute
   always_comb
   begin
      alu_op  = OP_NOP;
      alu_sel = SEL_NONE;
      if (is_jal)
         alu_sel = SEL_JUMP;                         // result is the link
      else if ((is_op || is_imm) && f7_ok)
      begin
         case (funct3)
            3'b000:
            begin
               alu_sel = SEL_ARITH;
               alu_op  = (is_op && funct7[5]) ? OP_SUB : OP_ADD;
            end
            3'b001:
            begin
               alu_sel = SEL_SHIFT;
               alu_op  = OP_SLL;
            end
            3'b010:
            begin
               alu_sel = SEL_ARITH;
               alu_op  = OP_SLT;
            end
            3'b011:
            begin
               alu_sel = SEL_ARITH;
               alu_op  = OP_SLTU;
            end
            3'b100:
            begin
               alu_sel = SEL_LOGIC;
               alu_op  = OP_XOR;
            end
            3'b101:
            begin
               alu_sel = SEL_SHIFT;
               alu_op  = funct7[5] ? OP_SRA : OP_SRL;
            end
            3'b110:
            begin
               alu_sel = SEL_LOGIC;
               alu_op  = OP_OR;
            end
            default:
            begin
               alu_sel = SEL_LOGIC;
               alu_op  = OP_AND;
            end
         endcase
      end
   end

   always_comb
   begin
      issue_d.valid   = in_valid;
      issue_d.pc      = fetch_i.pc;
      issue_d.alu_op  = alu_op;
      issue_d.alu_sel = alu_sel;
      issue_d.op_a    = src_a;
      if (is_op)
         issue_d.op_b = src_b;
      else if (is_shift)
         issue_d.op_b = {27'd0, instr[24:20]};       // shamt
      else
         issue_d.op_b = imm_i;
      issue_d.link    = fetch_i.pc + 32'd4;          // return address
      issue_d.rd      = rd;
      issue_d.wreg    = (alu_sel != SEL_NONE);       // unknown encodings write nothing
   end

   // ##############################
   // decode/execute register
   // ##############################
   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         issue_q.valid <= 1'b0;
         redirect_q    <= 1'b0;
      end
      else
      begin
         issue_q    <= issue_d;
         redirect_q <= in_valid && is_jal;           // one cycle per registered jal
      end
   end

   always_ff @(posedge clk_i)
   begin
      target_q <= fetch_i.pc + imm_j;                // jal target
   end

   assign issue_o    = issue_q;
   assign redirect_o = redirect_q;
   assign target_o   = target_q;

   // the jump being redirected is the one now in execute
   a_redirect_issue : assert property (@(posedge clk_i) disable iff (rst_i)
                                       redirect_o |-> issue_o.valid &&
                                                      (issue_o.alu_sel == SEL_JUMP));

endmodule

`default_nettype wire

// File: verilog/if_stage.sv
`timescale 1ns/1ps
`default_nettype none

module if_stage (
   input  wire                logic clk_i,
   input  wire                logic rst_i,
   input  wire                logic redirect_i,   // taken jal from decode
   input  cpu_pkg::addr_t     target_i,
   output logic               wb_cyc_o,
   output logic               wb_stb_o,
   output cpu_pkg::addr_t     wb_adr_o,
   input  cpu_pkg::word_t     wb_dat_i,
   input  wire                logic wb_ack_i,
   output cpu_pkg::fetch_t    fetch_o
);
   import cpu_pkg::*;

   typedef enum logic {
      IDLE = 1'b0,                                   // only right after reset
      BUSY = 1'b1                                    // cyc/stb held, next cycle follows ack
   } fetch_state_e;

   fetch_state_e state_q;
   addr_t        pc_q;                               // address of current/next fetch
   addr_t        tgt_q;                              // redirect target held for killed cycle
   logic         kill_q;                             // in-flight cycle belongs to old stream
   logic         deliver;
   fetch_t       fetch_d;
   fetch_t       fetch_q;

   // ##############################
   // bus side
   // ##############################
   assign wb_cyc_o = (state_q == BUSY);
   assign wb_stb_o = (state_q == BUSY);              // one transfer per cycle
   assign wb_adr_o = pc_q;                           // stable while busy, pc moves on ack only

   // response is kept only if nobody redirected meanwhile
   assign deliver = (state_q == BUSY) && wb_ack_i && !kill_q && !redirect_i;

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         state_q <= IDLE;
         pc_q    <= RESET_PC;
         kill_q  <= 1'b0;
      end
      else
      begin
         case (state_q)
            IDLE:
            begin
               state_q <= BUSY;                      // first cycle starts right away
               if (redirect_i)
                  pc_q <= target_i;                  // nothing in flight, jump directly
            end
            BUSY:
            begin
               if (wb_ack_i)
               begin
                  kill_q  <= 1'b0;                   // next cycle starts on this edge
                  if (redirect_i)
                     pc_q <= target_i;               // response dropped, restart at target
                  else if (kill_q)
                     pc_q <= tgt_q;                  // dropped earlier, restart at target
                  else
                     pc_q <= pc_q + 32'd4;           // sequential
               end
               else if (redirect_i)
                  kill_q <= 1'b1;                    // cycle must finish, then discard
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (redirect_i)
         tgt_q <= target_i;                          // only read while kill_q set
   end

   // ##############################
   // fetch register toward decode
   // ##############################
   always_comb
   begin
      fetch_d.valid = deliver;
      fetch_d.pc    = pc_q;
      fetch_d.instr = deliver ? wb_dat_i : NOP_INSTR;  // nop while empty
   end

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
         fetch_q.valid <= 1'b0;
      else
         fetch_q <= fetch_d;                         // valid for exactly one cycle
   end

   assign fetch_o = fetch_q;

   // address held until the slave acks
   a_adr_stable   : assert property (@(posedge clk_i) disable iff (rst_i)
                                     wb_stb_o && !wb_ack_i |=> wb_stb_o && $stable(wb_adr_o));

endmodule

`default_nettype wire

// File: verilog/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

   // ##############################
   // widths with meaning
   // ##############################
   typedef logic [31:0] word_t;                     // register value, result, instruction
   typedef logic [31:0] addr_t;                     // byte address
   typedef logic [4:0]  reg_addr_t;                 // register index

   // alu operation, one code per instruction kind
   typedef enum logic [3:0] {
      OP_NOP  = 4'd0,
      OP_AND  = 4'd1,
      OP_OR   = 4'd2,
      OP_XOR  = 4'd3,
      OP_SLL  = 4'd4,
      OP_SRL  = 4'd5,
      OP_SRA  = 4'd6,
      OP_ADD  = 4'd7,
      OP_SUB  = 4'd8,
      OP_SLT  = 4'd9,
      OP_SLTU = 4'd10
   } alu_op_e;

   // result group picked at the end of execute
   typedef enum logic [2:0] {
      SEL_NONE  = 3'd0,
      SEL_LOGIC = 3'd1,
      SEL_SHIFT = 3'd2,
      SEL_ARITH = 3'd3,
      SEL_JUMP  = 3'd4
   } alu_sel_e;

   // ##############################
   // encodings
   // ##############################
   localparam logic [6:0] OPC_OP     = 7'b0110011;  // reg-reg alu
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;  // reg-imm alu
   localparam logic [6:0] OPC_JAL    = 7'b1101111;  // jump and link

   localparam word_t NOP_INSTR = 32'h0000_0013;     // addi x0,x0,0
   localparam addr_t RESET_PC  = 32'h0000_0000;

   // ##############################
   // stage payloads
   // ##############################
   typedef struct packed {
      logic  valid;                                  // one cycle per accepted fetch
      addr_t pc;
      word_t instr;
   } fetch_t;

   typedef struct packed {
      logic      valid;
      addr_t     pc;                                 // carried through to commit
      alu_op_e   alu_op;
      alu_sel_e  alu_sel;
      word_t     op_a;
      word_t     op_b;
      word_t     link;                               // pc+4, used by jump group
      reg_addr_t rd;
      logic      wreg;
   } issue_t;

   typedef struct packed {
      logic      valid;
      addr_t     pc;
      reg_addr_t rd;
      logic      wreg;
      word_t     wdata;
   } commit_t;

endpackage

`default_nettype wire
